// File: verilog/fifo_ctrl_defines.svh
`ifndef FIFO_CTRL_DEFINES_SVH
`define FIFO_CTRL_DEFINES_SVH

// Pointer width, including the wrap bit above the RAM address.
`define FIFO_PTR_W 12

// RAM address width.
`define FIFO_ADDR_W 11

// Width of the user fill-level codes.
`define FIFO_LEVEL_W 4

// Capacities in entries of the port's own width.
`define FIFO_DEPTH_SMALL 512
`define FIFO_DEPTH_MID 1024
`define FIFO_DEPTH_LARGE 2048

// Below this count the level codes move in power-of-two steps.
`define FIFO_FINE_LIMIT 64

`endif

// File: verilog/fifo_ctrl_pkg.sv
`include "fifo_ctrl_defines.svh"

package fifo_ctrl_pkg;

	typedef logic [`FIFO_PTR_W-1:0] ptr_t;
	typedef logic [`FIFO_ADDR_W-1:0] addr_t;
	typedef logic [`FIFO_LEVEL_W-1:0] level_t;
	typedef logic [1:0] port_width_t;	// 00 x1, 01 x2, 10 x4.

	typedef enum logic [1:0] {
		DEPTH_SMALL,
		DEPTH_MID,
		DEPTH_LARGE
	} depth_class_e;

	typedef struct packed {
		logic        ram_mode;
		port_width_t push_width;
		port_width_t pop_width;
	} fifo_cfg_t;

	// Shift applies to the pop pointer as seen from the push side.
	// The push pointer seen from the pop side takes the mirror shift.
	typedef struct packed {
		depth_class_e push_class;
		depth_class_e pop_class;
		logic [1:0]   push_mask;
		logic [1:0]   pop_mask;
		logic         shift_left;
		logic [1:0]   shift_amt;	// 0 for equal widths.
	} ptr_map_t;

	typedef struct packed {
		ptr_t room_diff;	// Free entries, push units.
		ptr_t fill_diff;	// Stored entries, pop units.
	} occupancy_t;

	function automatic ptr_t depth_of(depth_class_e cls);
		case (cls)
			DEPTH_SMALL: return ptr_t'(`FIFO_DEPTH_SMALL);
			DEPTH_MID:   return ptr_t'(`FIFO_DEPTH_MID);
			default:     return ptr_t'(`FIFO_DEPTH_LARGE);
		endcase
	endfunction

endpackage

// File: verilog/fifo_ctrl_decode.sv
`timescale 1ns/100ps

module fifo_ctrl_decode import fifo_ctrl_pkg::*; (
	input  fifo_cfg_t cfg,
	output ptr_map_t  map
);

	localparam port_width_t W_X1 = 2'b00;
	localparam port_width_t W_X2 = 2'b01;
	localparam port_width_t W_X4 = 2'b10;

	function automatic depth_class_e class_of(logic ram_mode, port_width_t width);
		if (ram_mode == width[0])
		begin
			return DEPTH_MID;
		end
		else if (ram_mode == width[1])
		begin
			return DEPTH_SMALL;
		end
		return DEPTH_LARGE;
	endfunction

	always_comb
	begin
		map.push_class = class_of(cfg.ram_mode, cfg.push_width);
		map.pop_class  = class_of(cfg.ram_mode, cfg.pop_width);

		// Width ratio table.
		case ({cfg.push_width, cfg.pop_width})
			{W_X1, W_X2}:
			begin
				map.push_mask  = 2'b11;
				map.pop_mask   = 2'b01;
				map.shift_left = 1'b1;
				map.shift_amt  = 2'd1;
			end
			{W_X1, W_X4}:
			begin
				map.push_mask  = 2'b11;
				map.pop_mask   = 2'b00;
				map.shift_left = 1'b1;
				map.shift_amt  = 2'd2;
			end
			{W_X2, W_X1}:
			begin
				map.push_mask  = 2'b01;
				map.pop_mask   = 2'b11;
				map.shift_left = 1'b0;
				map.shift_amt  = 2'd1;
			end
			{W_X2, W_X4}:
			begin
				map.push_mask  = 2'b11;
				map.pop_mask   = 2'b01;
				map.shift_left = 1'b1;
				map.shift_amt  = 2'd1;
			end
			{W_X4, W_X1}:
			begin
				map.push_mask  = 2'b00;
				map.pop_mask   = 2'b11;
				map.shift_left = 1'b0;
				map.shift_amt  = 2'd2;
			end
			{W_X4, W_X2}:
			begin
				map.push_mask  = 2'b01;
				map.pop_mask   = 2'b11;
				map.shift_left = 1'b0;
				map.shift_amt  = 2'd1;
			end
			default:	// Equal or unsupported pairs.
			begin
				map.push_mask  = 2'b11;
				map.pop_mask   = 2'b11;
				map.shift_left = 1'b0;
				map.shift_amt  = 2'd0;
			end
		endcase
	end

endmodule

// File: verilog/fifo_ctrl_execute.sv
`timescale 1ns/100ps
`include "fifo_ctrl_defines.svh"

module fifo_ctrl_execute import fifo_ctrl_pkg::*; (
	input  logic       Pop_Clk,
	input  logic       Rst_n,
	input  logic       push,
	input  logic       pop,
	input  logic       push_flush,
	input  logic       pop_flush,
	input  ptr_map_t   map,
	output occupancy_t occ,
	output logic       clear,
	output addr_t      write_addr,
	output addr_t      read_addr
);

	ptr_t push_ptr;
	ptr_t pop_ptr;
	ptr_t next_push;
	ptr_t next_pop;
	ptr_t pop_in_push;
	ptr_t push_in_pop;
	ptr_t push_fill;
	ptr_t push_cap;
	ptr_t pop_cap;
	ptr_t write_ptr;
	ptr_t read_ptr;

	// Limits the top two pointer bits to the side's wrap range.
	function automatic ptr_t wrap(ptr_t p, logic [1:0] mask);
		return {mask & p[`FIFO_PTR_W-1 -: 2], p[`FIFO_PTR_W-3:0]};
	endfunction

	function automatic ptr_t scale(ptr_t p, logic left, logic [1:0] amt);
		if (left)
		begin
			return p << amt;
		end
		return p >> amt;
	endfunction

	assign clear = push_flush | pop_flush;

	assign next_push = wrap(push ? push_ptr + 1'b1 : push_ptr, map.push_mask);
	assign next_pop  = wrap(pop ? pop_ptr + 1'b1 : pop_ptr, map.pop_mask);

	// Each pointer brought into the other side's units.
	assign pop_in_push = scale(next_pop, map.shift_left, map.shift_amt);
	assign push_in_pop = scale(next_push, ~map.shift_left, map.shift_amt);

	assign push_cap = depth_of(map.push_class);
	assign pop_cap  = depth_of(map.pop_class);

	assign push_fill     = wrap(next_push - pop_in_push, map.push_mask);
	assign occ.room_diff = push_cap - push_fill;
	assign occ.fill_diff = wrap(push_in_pop - next_pop, map.pop_mask);

	// RAM address wraps at the side's capacity.
	assign write_ptr = push_ptr & (push_cap - 1'b1);
	assign read_ptr  = next_pop & (pop_cap - 1'b1);	// Lookahead by one.

	assign write_addr = write_ptr[`FIFO_ADDR_W-1:0];
	assign read_addr  = read_ptr[`FIFO_ADDR_W-1:0];

	always_ff @(posedge Pop_Clk or negedge Rst_n)
	begin
		if (~Rst_n)
		begin
			push_ptr <= '0;
			pop_ptr  <= '0;
		end
		else if (clear)
		begin
			push_ptr <= '0;	// Either flush empties the FIFO.
			pop_ptr  <= '0;
		end
		else
		begin
			push_ptr <= next_push;
			pop_ptr  <= next_pop;
		end
	end

endmodule

// File: verilog/fifo_ctrl_result.sv
`timescale 1ns/100ps
`include "fifo_ctrl_defines.svh"

module fifo_ctrl_result import fifo_ctrl_pkg::*; (
	input  logic       Pop_Clk,
	input  logic       Rst_n,
	input  occupancy_t occ,
	input  ptr_map_t   map,
	input  logic       clear,
	output logic       full,
	output logic       empty,
	output level_t     full_level,
	output level_t     empty_level
);

	localparam level_t FULL_LEVEL_RST  = 4'b0001;
	localparam level_t EMPTY_LEVEL_RST = 4'b0000;

	ptr_t   push_cap;
	ptr_t   pop_cap;
	logic   room_fine;
	logic   fill_fine;
	logic   full_nxt;
	logic   empty_nxt;
	level_t full_level_nxt;
	level_t empty_level_nxt;

	assign push_cap = depth_of(map.push_class);
	assign pop_cap  = depth_of(map.pop_class);

	assign room_fine = occ.room_diff < ptr_t'(`FIFO_FINE_LIMIT);
	assign fill_fine = occ.fill_diff < ptr_t'(`FIFO_FINE_LIMIT);

	assign full_nxt  = occ.room_diff < ptr_t'(2);
	assign empty_nxt = occ.fill_diff < ptr_t'(2);	// Read side runs one ahead.

	always_comb
	begin
		if (occ.room_diff == '0)
			full_level_nxt = 4'b0000;
		else if (occ.room_diff == push_cap)
			full_level_nxt = 4'b0001;
		else if (occ.room_diff >= (push_cap >> 1))
			full_level_nxt = 4'b0010;
		else if (occ.room_diff >= (push_cap >> 2))
			full_level_nxt = 4'b0011;
		else if (!room_fine)
			full_level_nxt = 4'b0100;
		else if (occ.room_diff[5])
			full_level_nxt = 4'b1010;
		else if (occ.room_diff[4])
			full_level_nxt = 4'b1011;
		else if (occ.room_diff[3])
			full_level_nxt = 4'b1100;
		else if (occ.room_diff[2])
			full_level_nxt = 4'b1101;
		else if (occ.room_diff[1])
			full_level_nxt = 4'b1110;
		else
			full_level_nxt = 4'b1111;	// One entry of room.
	end

	always_comb
	begin
		if (occ.fill_diff == pop_cap)
			empty_level_nxt = 4'b1111;
		else if (occ.fill_diff >= (pop_cap >> 1))
			empty_level_nxt = 4'b1110;
		else if (occ.fill_diff >= (pop_cap >> 2))
			empty_level_nxt = 4'b1101;
		else if (!fill_fine)
			empty_level_nxt = 4'b1000;
		else if (occ.fill_diff[5])
			empty_level_nxt = 4'b0110;
		else if (occ.fill_diff[4])
			empty_level_nxt = 4'b0101;
		else if (occ.fill_diff[3])
			empty_level_nxt = 4'b0100;
		else if (occ.fill_diff[2])
			empty_level_nxt = 4'b0011;
		else if (occ.fill_diff[1])
			empty_level_nxt = 4'b0010;
		else if (occ.fill_diff[0])
			empty_level_nxt = 4'b0001;
		else
			empty_level_nxt = 4'b0000;
	end

	always_ff @(posedge Pop_Clk or negedge Rst_n)
	begin
		if (~Rst_n)
		begin
			full        <= 1'b0;
			empty       <= 1'b1;
			full_level  <= FULL_LEVEL_RST;
			empty_level <= EMPTY_LEVEL_RST;
		end
		else if (clear)
		begin
			full        <= 1'b0;	// Same as after reset.
			empty       <= 1'b1;
			full_level  <= FULL_LEVEL_RST;
			empty_level <= EMPTY_LEVEL_RST;
		end
		else
		begin
			full        <= full_nxt;
			empty       <= empty_nxt;
			full_level  <= full_level_nxt;
			empty_level <= empty_level_nxt;
		end
	end

endmodule

// File: verilog/fifo_ctrl_top.sv
`timescale 1ns/100ps

module fifo_ctrl_top import fifo_ctrl_pkg::*; (
	input  logic      Pop_Clk,
	input  logic      Rst_n,
	input  logic      push,
	input  logic      pop,
	input  logic      push_flush,
	input  logic      pop_flush,
	input  fifo_cfg_t cfg,
	output logic      full,
	output logic      empty,
	output level_t    full_level,
	output level_t    empty_level,
	output addr_t     write_addr,
	output addr_t     read_addr
);

	ptr_map_t   map;
	occupancy_t occ;
	logic       clear;

	fifo_ctrl_decode u_decode (
		.cfg (cfg),
		.map (map)
	);

	fifo_ctrl_execute u_execute (
		.Pop_Clk    (Pop_Clk),
		.Rst_n      (Rst_n),
		.push       (push),
		.pop        (pop),
		.push_flush (push_flush),
		.pop_flush  (pop_flush),
		.map        (map),
		.occ        (occ),
		.clear      (clear),
		.write_addr (write_addr),
		.read_addr  (read_addr)
	);

	fifo_ctrl_result u_result (
		.Pop_Clk     (Pop_Clk),
		.Rst_n       (Rst_n),
		.occ         (occ),
		.map         (map),
		.clear       (clear),
		.full        (full),
		.empty       (empty),
		.full_level  (full_level),
		.empty_level (empty_level)
	);

endmodule

// File: dv/fifo_ctrl_tb.sv
`timescale 1ns/100ps

module fifo_ctrl_tb import fifo_ctrl_pkg::*; ();

	localparam int CLK_HALF       = 50;
	localparam int RESET_CYCLES   = 3;
	localparam int NUM_FIELDS     = 13;
	localparam int NUM_CASES      = 32;
	localparam int SETTLE_TIMEOUT = 8;
	localparam int MAX_GAP        = 3;
	localparam int SAMPLE_DELAY   = 1;

	typedef struct packed {
		logic   full;
		logic   empty;
		level_t full_level;
		level_t empty_level;
		addr_t  write_addr;
		addr_t  read_addr;
	} status_t;

	logic      Pop_Clk;
	logic      Rst_n;
	logic      push;
	logic      pop;
	logic      push_flush;
	logic      pop_flush;
	fifo_cfg_t cfg;
	logic      full;
	logic      empty;
	level_t    full_level;
	level_t    empty_level;
	addr_t     write_addr;
	addr_t     read_addr;

	logic [15:0] case_words [0:NUM_FIELDS*NUM_CASES-1];
	integer      seed = 32'h4589;

	fifo_ctrl_top u_dut (
		.Pop_Clk     (Pop_Clk),
		.Rst_n       (Rst_n),
		.push        (push),
		.pop         (pop),
		.push_flush  (push_flush),
		.pop_flush   (pop_flush),
		.cfg         (cfg),
		.full        (full),
		.empty       (empty),
		.full_level  (full_level),
		.empty_level (empty_level),
		.write_addr  (write_addr),
		.read_addr   (read_addr)
	);

	initial
	begin
		Pop_Clk = 1'b0;
		forever
		begin
			#CLK_HALF Pop_Clk = ~Pop_Clk;
		end
	end

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first failure.");
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
			abort_run();
		end
	endtask

	function automatic status_t sample_outputs();
		return {full, empty, full_level, empty_level, write_addr, read_addr};
	endfunction

	task automatic verify_outputs(input string tag, input status_t exp);
		compare_value({tag, " full"}, exp.full, full);
		compare_value({tag, " empty"}, exp.empty, empty);
		compare_value({tag, " full_level"}, exp.full_level, full_level);
		compare_value({tag, " empty_level"}, exp.empty_level, empty_level);
		compare_value({tag, " write_addr"}, exp.write_addr, write_addr);
		compare_value({tag, " read_addr"}, exp.read_addr, read_addr);
	endtask

	// Outputs must hold still over one idle cycle.
	task automatic wait_settled(input string tag);
		status_t prev;
		logic    settled;
		int      cycles;
		prev    = sample_outputs();
		settled = 1'b0;
		cycles  = 0;
		while (!settled && cycles < SETTLE_TIMEOUT)
		begin
			@(negedge Pop_Clk);
			cycles++;
			settled = (sample_outputs() === prev);
			prev    = sample_outputs();
		end
		if (!settled)
		begin
			$display("%s: outputs kept changing for %0d idle cycles", tag, SETTLE_TIMEOUT);
			abort_run();
		end
	endtask

	task automatic idle_gap();
		int gap;
		gap = $unsigned($random(seed)) % MAX_GAP;
		for (int i = 0; i < gap; i++)
		begin
			@(negedge Pop_Clk);
		end
	endtask

	// No gap after the last strobe, so the check sees the one-cycle latency.
	task automatic push_entries(input int count);
		for (int i = 0; i < count; i++)
		begin
			push = 1'b1;
			@(negedge Pop_Clk);
			push = 1'b0;
			if (i < count - 1)
			begin
				idle_gap();
			end
		end
	endtask

	task automatic pop_entries(input int count);
		for (int i = 0; i < count; i++)
		begin
			pop = 1'b1;
			@(negedge Pop_Clk);
			pop = 1'b0;
			if (i < count - 1)
			begin
				idle_gap();
			end
		end
	endtask

	task automatic flush_fifo(input logic use_pop);
		push_flush = ~use_pop;
		pop_flush  = use_pop;
		@(negedge Pop_Clk);
		push_flush = 1'b0;
		pop_flush  = 1'b0;
	endtask

	task automatic load_cfg(input fifo_cfg_t new_cfg);
		cfg = new_cfg;	// Changed only while a flush is held.
		flush_fifo(1'b0);
	endtask

	initial
	begin
		status_t   exp;
		fifo_cfg_t line_cfg;
		string     tag;
		int        base;
		int        flush_sel;
		push       = 1'b0;
		pop        = 1'b0;
		push_flush = 1'b0;
		pop_flush  = 1'b0;
		cfg        = '0;
		Rst_n      = 1'b0;
		$readmemh("dv/fifo_ctrl_cases.txt", case_words);
		if ($isunknown(case_words[NUM_FIELDS*NUM_CASES-1]))
		begin
			$display("Case file dv/fifo_ctrl_cases.txt is missing or too short.");
			abort_run();
		end
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			@(negedge Pop_Clk);
		end
		Rst_n = 1'b1;

		for (int n = 0; n < NUM_CASES; n++)
		begin
			base = n * NUM_FIELDS;
			tag  = $sformatf("case %0d", case_words[base]);
			line_cfg.ram_mode   = case_words[base+1][0];
			line_cfg.push_width = case_words[base+2][1:0];
			line_cfg.pop_width  = case_words[base+3][1:0];
			flush_sel           = case_words[base+6];
			exp.full        = case_words[base+7][0];
			exp.empty       = case_words[base+8][0];
			exp.full_level  = case_words[base+9][3:0];
			exp.empty_level = case_words[base+10][3:0];
			exp.write_addr  = case_words[base+11][10:0];
			exp.read_addr   = case_words[base+12][10:0];
			if (line_cfg != cfg)
			begin
				load_cfg(line_cfg);
			end
			push_entries(case_words[base+4]);
			pop_entries(case_words[base+5]);
			if (flush_sel == 1)
			begin
				flush_fifo(1'b0);
			end
			else if (flush_sel == 2)
			begin
				flush_fifo(1'b1);
			end
			#SAMPLE_DELAY;	// Released strobes reach read_addr.
			verify_outputs(tag, exp);
			wait_settled(tag);
			verify_outputs({tag, " settled"}, exp);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: fifo_ctrl.f
+incdir+verilog
verilog/fifo_ctrl_pkg.sv
verilog/fifo_ctrl_decode.sv
verilog/fifo_ctrl_execute.sv
verilog/fifo_ctrl_result.sv
verilog/fifo_ctrl_top.sv
dv/fifo_ctrl_tb.sv

// File: Bender.yml
package:
  name: fifo_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fifo_ctrl_pkg.sv
      - verilog/fifo_ctrl_decode.sv
      - verilog/fifo_ctrl_execute.sv
      - verilog/fifo_ctrl_result.sv
      - verilog/fifo_ctrl_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/fifo_ctrl_tb.sv

// File: dv/fifo_ctrl_cases.txt
// id ram_mode push_w pop_w pushes pops flush(0 none 1 push 2 pop) | full empty
// full_level empty_level write_addr read_addr; widths 0 x1 1 x2 2 x4, all hex.
// Counts add to the state left by the previous case; a new cfg starts empty.
00 0 0 0 000 000 0  0 1 1 0 000 000
// Equal x2 widths, small class, filling.
01 0 1 1 001 000 0  0 1 2 1 001 000
02 0 1 1 002 000 0  0 0 2 2 003 000
03 0 1 1 011 000 0  0 0 2 5 014 000
04 0 1 1 014 000 0  0 0 2 6 028 000
05 0 1 1 03C 000 0  0 0 2 8 064 000
06 0 1 1 09C 000 0  0 0 2 E 100 000
07 0 1 1 080 000 0  0 0 3 E 180 000
08 0 1 1 07F 000 0  1 0 F E 1FF 000
09 0 1 1 001 000 0  1 0 0 F 000 000
// Drain from full.
0A 0 1 1 000 001 0  1 0 F E 000 001
0B 0 1 1 000 0FF 0  0 0 2 E 000 100
0C 0 1 1 000 080 0  0 0 2 D 000 180
0D 0 1 1 000 040 0  0 0 2 8 000 1C0
0E 0 1 1 000 018 0  0 0 2 6 000 1D8
0F 0 1 1 000 01E 0  0 0 2 4 000 1F6
10 0 1 1 000 008 0  0 0 2 2 000 1FE
11 0 1 1 000 001 0  0 1 2 1 000 1FF
12 0 1 1 000 001 0  0 1 1 0 000 000
// Flushes after a partial fill.
13 0 1 1 032 00A 0  0 0 2 6 032 00A
14 0 1 1 01E 005 1  0 1 1 0 000 000
15 0 1 1 04D 00C 2  0 1 1 0 000 000
16 0 1 1 005 000 0  0 0 2 3 005 000
// Push x1, pop x2.
17 0 0 1 028 000 0  0 0 2 5 028 000
18 0 0 1 3C0 000 0  0 0 B E 3E8 000
19 0 0 1 000 064 0  0 0 4 E 3E8 064
// Push x2, pop x1.
1A 0 1 0 064 000 0  0 0 2 8 064 000
1B 0 1 0 190 000 0  0 0 C E 1F4 000
1C 0 1 0 000 3E6 0  0 0 2 2 1F4 3E6
// Same push count in the small, mid and large classes.
1D 0 1 1 12C 000 0  0 0 3 E 12C 000
1E 0 0 0 12C 000 0  0 0 2 D 12C 000
1F 1 0 0 12C 000 0  0 0 2 8 12C 000
